//--- mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    localparam int NB_INSTR  = 32;
    localparam int NB_OPCODE = 6;
    localparam int NB_REGS   = 5;
    localparam int NB_IMM    = 16;
    localparam int NB_TARGET = 26;

    localparam logic [NB_OPCODE-1:0] OP_RTYPE = 6'b000000;
    localparam logic [NB_OPCODE-1:0] OP_ADDI  = 6'b001000;
    localparam logic [NB_OPCODE-1:0] OP_ANDI  = 6'b001100;
    localparam logic [NB_OPCODE-1:0] OP_BEQ   = 6'b000100;
    localparam logic [NB_OPCODE-1:0] OP_JUMP  = 6'b000010;
    localparam logic [NB_OPCODE-1:0] OP_LW    = 6'b100011;
    localparam logic [NB_OPCODE-1:0] OP_LB    = 6'b100000;
    localparam logic [NB_OPCODE-1:0] OP_SW    = 6'b101011;
    localparam logic [NB_OPCODE-1:0] OP_SB    = 6'b101000;

    // One instruction word, read as R, I or J format.
    // The opcode sits in the same six bits in all three views.
    typedef union packed {
        struct packed {
            logic [NB_OPCODE-1:0] opcode;
            logic [NB_REGS-1:0]   rs;
            logic [NB_REGS-1:0]   rt;
            logic [NB_REGS-1:0]   rd;
            logic [NB_REGS-1:0]   shamt;
            logic [NB_OPCODE-1:0] funct;
        } r_fmt;
        struct packed {
            logic [NB_OPCODE-1:0] opcode;
            logic [NB_REGS-1:0]   rs;
            logic [NB_REGS-1:0]   rt;
            logic [NB_IMM-1:0]    imm;
        } i_fmt;
        struct packed {
            logic [NB_OPCODE-1:0] opcode;
            logic [NB_TARGET-1:0] target;
        } j_fmt;
    } instr_u;

endpackage

`default_nettype wire

//--- decode_ctrl_pkg.sv
`default_nettype none

package decode_ctrl_pkg;

    // Second ALU operand.
    localparam logic ALU_SRC_RT  = 1'b0;
    localparam logic ALU_SRC_IMM = 1'b1;

    // Immediate extension modes.
    localparam int NB_EXT_MODE = 2;
    localparam logic [NB_EXT_MODE-1:0] EXT_SIGNED   = 2'd0;
    localparam logic [NB_EXT_MODE-1:0] EXT_UNSIGNED = 2'd1;
    localparam logic [NB_EXT_MODE-1:0] EXT_TARGET   = 2'd2;

    // Memory access size.
    localparam int NB_SIZE_TYPE = 3;
    localparam logic [NB_SIZE_TYPE-1:0] WORD_FULL = 3'b000;
    localparam logic [NB_SIZE_TYPE-1:0] WORD_BYTE = 3'b001;

    // Number of decode lanes, kept a power of two so the pointers wrap on their own.
    localparam int NUM_LANES   = 4;
    localparam int NB_LANE_IDX = $clog2(NUM_LANES);

endpackage

`default_nettype wire

//--- decode_result_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_result_if;

    logic                                      req;
    logic                                      ack;
    logic                                      alu_src;
    logic                                      mem_read;
    logic                                      mem_write;
    logic                                      reg_write;
    logic                                      branch;
    logic                                      jump;
    logic [mips_isa_pkg::NB_REGS-1:0]          reg_dst;
    logic [decode_ctrl_pkg::NB_SIZE_TYPE-1:0]  word_size;
    logic [mips_isa_pkg::NB_INSTR-1:0]         imm_ext;

    modport lane_mp (
        output req, alu_src, mem_read, mem_write, reg_write, branch, jump,
        output reg_dst, word_size, imm_ext,
        input  ack
    );

    modport coll_mp (
        input  req, alu_src, mem_read, mem_write, reg_write, branch, jump,
        input  reg_dst, word_size, imm_ext,
        output ack
    );

endinterface

`default_nettype wire

//--- control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  mips_isa_pkg::instr_u                      i_instr,
    output logic                                      o_alu_src,
    output logic                                      o_mem_read,
    output logic                                      o_mem_write,
    output logic                                      o_reg_write,
    output logic                                      o_branch,
    output logic                                      o_jump,
    output logic [mips_isa_pkg::NB_REGS-1:0]          o_reg_dst,
    output logic [decode_ctrl_pkg::NB_EXT_MODE-1:0]   o_ext_mode,
    output logic [decode_ctrl_pkg::NB_SIZE_TYPE-1:0]  o_word_size
);

    always_comb begin
        o_alu_src   = decode_ctrl_pkg::ALU_SRC_RT;
        o_mem_read  = 1'b0;
        o_mem_write = 1'b0;
        o_reg_write = 1'b0;
        o_branch    = 1'b0;
        o_jump      = 1'b0;
        o_reg_dst   = '0;
        o_ext_mode  = decode_ctrl_pkg::EXT_SIGNED;
        o_word_size = decode_ctrl_pkg::WORD_FULL;

        case (i_instr.r_fmt.opcode)
            mips_isa_pkg::OP_RTYPE: begin
                o_reg_write = 1'b1;
                o_reg_dst   = i_instr.r_fmt.rd;
            end
            mips_isa_pkg::OP_ADDI: begin
                o_alu_src   = decode_ctrl_pkg::ALU_SRC_IMM;
                o_reg_write = 1'b1;
                o_reg_dst   = i_instr.i_fmt.rt;
            end
            mips_isa_pkg::OP_ANDI: begin
                o_alu_src   = decode_ctrl_pkg::ALU_SRC_IMM;
                o_reg_write = 1'b1;
                o_reg_dst   = i_instr.i_fmt.rt;
                o_ext_mode  = decode_ctrl_pkg::EXT_UNSIGNED;
            end
            mips_isa_pkg::OP_BEQ: begin
                o_branch = 1'b1;
            end
            mips_isa_pkg::OP_JUMP: begin
                o_jump     = 1'b1;
                o_reg_dst  = i_instr.i_fmt.rt;
                o_ext_mode = decode_ctrl_pkg::EXT_TARGET;
            end
            mips_isa_pkg::OP_LW, mips_isa_pkg::OP_LB: begin
                o_alu_src   = decode_ctrl_pkg::ALU_SRC_IMM;
                o_mem_read  = 1'b1;
                o_reg_write = 1'b1;
                o_reg_dst   = i_instr.i_fmt.rt;
                if (i_instr.i_fmt.opcode == mips_isa_pkg::OP_LB) begin
                    o_word_size = decode_ctrl_pkg::WORD_BYTE;
                end
            end
            mips_isa_pkg::OP_SW, mips_isa_pkg::OP_SB: begin
                o_alu_src   = decode_ctrl_pkg::ALU_SRC_IMM;
                o_mem_write = 1'b1;
                if (i_instr.i_fmt.opcode == mips_isa_pkg::OP_SB) begin
                    o_word_size = decode_ctrl_pkg::WORD_BYTE;
                end
            end
            default: begin
                // Unknown opcodes decode to a no-op.
            end
        endcase
    end

endmodule

`default_nettype wire

//--- decode_lane.sv
`timescale 1ns/1ps
`default_nettype none

module decode_lane (
    input  logic                   i_clk,
    input  logic                   i_rst,
    input  logic                   i_lane_req,
    input  mips_isa_pkg::instr_u   i_lane_instr,
    output logic                   o_lane_ack,
    decode_result_if.lane_mp       o_res
);

    typedef enum logic [1:0] {S_IDLE, S_FULL, S_OFFER, S_DRAIN} lane_state_e;

    lane_state_e                                      state;
    logic                                             capture;
    logic                                             alu_src;
    logic                                             mem_read;
    logic                                             mem_write;
    logic                                             reg_write;
    logic                                             branch;
    logic                                             jump;
    logic [mips_isa_pkg::NB_REGS-1:0]                 reg_dst;
    logic [decode_ctrl_pkg::NB_EXT_MODE-1:0]          ext_mode;
    logic [decode_ctrl_pkg::NB_SIZE_TYPE-1:0]         word_size;
    logic [mips_isa_pkg::NB_INSTR-1:0]                imm_ext;

    control_unit u_control_unit (
        .i_instr     (i_lane_instr),
        .o_alu_src   (alu_src),
        .o_mem_read  (mem_read),
        .o_mem_write (mem_write),
        .o_reg_write (reg_write),
        .o_branch    (branch),
        .o_jump      (jump),
        .o_reg_dst   (reg_dst),
        .o_ext_mode  (ext_mode),
        .o_word_size (word_size)
    );

    always_comb begin
        case (ext_mode)
            decode_ctrl_pkg::EXT_UNSIGNED:
                imm_ext = {{(mips_isa_pkg::NB_INSTR - mips_isa_pkg::NB_IMM){1'b0}},
                           i_lane_instr.i_fmt.imm};
            decode_ctrl_pkg::EXT_TARGET:
                imm_ext = {{(mips_isa_pkg::NB_INSTR - mips_isa_pkg::NB_TARGET){1'b0}},
                           i_lane_instr.j_fmt.target};
            default:
                imm_ext = {{(mips_isa_pkg::NB_INSTR - mips_isa_pkg::NB_IMM)
                            {i_lane_instr.i_fmt.imm[mips_isa_pkg::NB_IMM-1]}},
                           i_lane_instr.i_fmt.imm};
        endcase
    end

    // A new word is taken only once the previous input handshake has fully closed.
    assign capture = (state == S_IDLE) && i_lane_req && !o_lane_ack;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state      <= S_IDLE;
            o_lane_ack <= 1'b0;
        end else begin
            if (o_lane_ack && !i_lane_req) begin
                o_lane_ack <= 1'b0;
            end
            case (state)
                S_IDLE:  if (capture) begin
                    o_lane_ack <= 1'b1;
                    state      <= S_FULL;
                end
                S_FULL:  state <= S_OFFER;
                S_OFFER: if (o_res.ack) state <= S_DRAIN;
                S_DRAIN: if (!o_res.ack) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (capture) begin
            o_res.alu_src   <= alu_src;
            o_res.mem_read  <= mem_read;
            o_res.mem_write <= mem_write;
            o_res.reg_write <= reg_write;
            o_res.branch    <= branch;
            o_res.jump      <= jump;
            o_res.reg_dst   <= reg_dst;
            o_res.word_size <= word_size;
            o_res.imm_ext   <= imm_ext;
        end
    end

    assign o_res.req = (state == S_OFFER);

endmodule

`default_nettype wire

//--- decode_dispatcher.sv
`timescale 1ns/1ps
`default_nettype none

module decode_dispatcher (
    input  logic                                    i_clk,
    input  logic                                    i_rst,
    input  logic                                    i_instr_req,
    output logic                                    o_instr_ack,
    input  mips_isa_pkg::instr_u                    i_instr,
    output logic [decode_ctrl_pkg::NUM_LANES-1:0]   o_lane_req,
    output mips_isa_pkg::instr_u                    o_lane_instr [decode_ctrl_pkg::NUM_LANES],
    input  logic [decode_ctrl_pkg::NUM_LANES-1:0]   i_lane_ack
);

    typedef enum logic [1:0] {D_IDLE, D_SEND, D_ACK} disp_state_e;

    disp_state_e                              state;
    logic [decode_ctrl_pkg::NB_LANE_IDX-1:0]  ptr;
    logic                                     launch;

    // Words go strictly to the pointed lane, so order is kept without tags.
    assign launch = (state == D_IDLE) && i_instr_req && !i_lane_ack[ptr];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state       <= D_IDLE;
            ptr         <= '0;
            o_instr_ack <= 1'b0;
            o_lane_req  <= '0;
        end else begin
            case (state)
                D_IDLE: if (launch) begin
                    o_lane_req[ptr] <= 1'b1;
                    state           <= D_SEND;
                end
                D_SEND: if (i_lane_ack[ptr]) begin
                    o_lane_req[ptr] <= 1'b0;
                    o_instr_ack     <= 1'b1;
                    state           <= D_ACK;
                end
                D_ACK: if (!i_instr_req && !i_lane_ack[ptr]) begin
                    o_instr_ack <= 1'b0;
                    ptr         <= decode_ctrl_pkg::NB_LANE_IDX'(ptr + 1'b1);
                    state       <= D_IDLE;
                end
                default: state <= D_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (launch) begin
            o_lane_instr[ptr] <= i_instr;
        end
    end

endmodule

`default_nettype wire

//--- decode_collector.sv
`timescale 1ns/1ps
`default_nettype none

module decode_collector (
    input  logic                                      i_clk,
    input  logic                                      i_rst,
    decode_result_if.coll_mp                          i_res [decode_ctrl_pkg::NUM_LANES],
    output logic                                      o_dec_req,
    input  logic                                      i_dec_ack,
    output logic                                      o_alu_src,
    output logic                                      o_mem_read,
    output logic                                      o_mem_write,
    output logic                                      o_reg_write,
    output logic                                      o_branch,
    output logic                                      o_jump,
    output logic [mips_isa_pkg::NB_REGS-1:0]          o_reg_dst,
    output logic [decode_ctrl_pkg::NB_SIZE_TYPE-1:0]  o_word_size,
    output logic [mips_isa_pkg::NB_INSTR-1:0]         o_imm_ext
);

    localparam int N = decode_ctrl_pkg::NUM_LANES;

    typedef enum logic [1:0] {C_IDLE, C_LANE, C_OUT} coll_state_e;

    coll_state_e                              state;
    logic [decode_ctrl_pkg::NB_LANE_IDX-1:0]  ptr;
    logic                                     take;
    logic [N-1:0]                             lane_req;
    logic [N-1:0]                             lane_ack;
    logic [N-1:0]                             lane_flags [6];
    logic [mips_isa_pkg::NB_REGS-1:0]         lane_reg_dst [N];
    logic [decode_ctrl_pkg::NB_SIZE_TYPE-1:0] lane_word_size [N];
    logic [mips_isa_pkg::NB_INSTR-1:0]        lane_imm_ext [N];

    // Interface arrays only take constant indices, so each lane is copied out here.
    for (genvar g = 0; g < N; g++) begin : g_lane
        assign lane_req[g]       = i_res[g].req;
        assign i_res[g].ack      = lane_ack[g];
        assign lane_flags[0][g]  = i_res[g].alu_src;
        assign lane_flags[1][g]  = i_res[g].mem_read;
        assign lane_flags[2][g]  = i_res[g].mem_write;
        assign lane_flags[3][g]  = i_res[g].reg_write;
        assign lane_flags[4][g]  = i_res[g].branch;
        assign lane_flags[5][g]  = i_res[g].jump;
        assign lane_reg_dst[g]   = i_res[g].reg_dst;
        assign lane_word_size[g] = i_res[g].word_size;
        assign lane_imm_ext[g]   = i_res[g].imm_ext;
    end

    assign take = (state == C_IDLE) && lane_req[ptr];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state     <= C_IDLE;
            ptr       <= '0;
            o_dec_req <= 1'b0;
            lane_ack  <= '0;
        end else begin
            // The output side may be acknowledged while the lane side is still closing.
            if (o_dec_req && i_dec_ack) begin
                o_dec_req <= 1'b0;
            end
            case (state)
                C_IDLE: if (take) begin
                    o_dec_req     <= 1'b1;
                    lane_ack[ptr] <= 1'b1;
                    state         <= C_LANE;
                end
                C_LANE: if (!lane_req[ptr]) begin
                    lane_ack[ptr] <= 1'b0;
                    state         <= C_OUT;
                end
                C_OUT: if (!o_dec_req && !i_dec_ack) begin
                    ptr   <= decode_ctrl_pkg::NB_LANE_IDX'(ptr + 1'b1);
                    state <= C_IDLE;
                end
                default: state <= C_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (take) begin
            o_alu_src   <= lane_flags[0][ptr];
            o_mem_read  <= lane_flags[1][ptr];
            o_mem_write <= lane_flags[2][ptr];
            o_reg_write <= lane_flags[3][ptr];
            o_branch    <= lane_flags[4][ptr];
            o_jump      <= lane_flags[5][ptr];
            o_reg_dst   <= lane_reg_dst[ptr];
            o_word_size <= lane_word_size[ptr];
            o_imm_ext   <= lane_imm_ext[ptr];
        end
    end

endmodule

`default_nettype wire

//--- decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_top (
    input  logic                                      i_clk,
    input  logic                                      i_rst,
    input  logic                                      i_instr_req,
    output logic                                      o_instr_ack,
    input  logic [mips_isa_pkg::NB_INSTR-1:0]         i_instr,
    output logic                                      o_dec_req,
    input  logic                                      i_dec_ack,
    output logic                                      o_alu_src,
    output logic                                      o_mem_read,
    output logic                                      o_mem_write,
    output logic                                      o_reg_write,
    output logic                                      o_branch,
    output logic                                      o_jump,
    output logic [mips_isa_pkg::NB_REGS-1:0]          o_reg_dst,
    output logic [decode_ctrl_pkg::NB_SIZE_TYPE-1:0]  o_word_size,
    output logic [mips_isa_pkg::NB_INSTR-1:0]         o_imm_ext
);

    logic [decode_ctrl_pkg::NUM_LANES-1:0]  lane_req;
    logic [decode_ctrl_pkg::NUM_LANES-1:0]  lane_ack;
    mips_isa_pkg::instr_u                   lane_instr [decode_ctrl_pkg::NUM_LANES];

    decode_result_if res_if [decode_ctrl_pkg::NUM_LANES] ();

    decode_dispatcher u_dispatcher (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_instr_req  (i_instr_req),
        .o_instr_ack  (o_instr_ack),
        .i_instr      (i_instr),
        .o_lane_req   (lane_req),
        .o_lane_instr (lane_instr),
        .i_lane_ack   (lane_ack)
    );

    for (genvar g = 0; g < decode_ctrl_pkg::NUM_LANES; g++) begin : g_lanes
        decode_lane u_lane (
            .i_clk        (i_clk),
            .i_rst        (i_rst),
            .i_lane_req   (lane_req[g]),
            .i_lane_instr (lane_instr[g]),
            .o_lane_ack   (lane_ack[g]),
            .o_res        (res_if[g])
        );
    end

    decode_collector u_collector (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_res       (res_if),
        .o_dec_req   (o_dec_req),
        .i_dec_ack   (i_dec_ack),
        .o_alu_src   (o_alu_src),
        .o_mem_read  (o_mem_read),
        .o_mem_write (o_mem_write),
        .o_reg_write (o_reg_write),
        .o_branch    (o_branch),
        .o_jump      (o_jump),
        .o_reg_dst   (o_reg_dst),
        .o_word_size (o_word_size),
        .o_imm_ext   (o_imm_ext)
    );

endmodule

`default_nettype wire

//--- decode_top_props.sv
`timescale 1ns/1ps
`default_nettype none

module decode_top_props (
    input  logic         i_clk,
    input  logic         i_rst,
    input  logic         i_instr_req,
    input  logic         o_instr_ack,
    input  logic         o_dec_req,
    input  logic         i_dec_ack,
    input  logic         o_alu_src,
    input  logic         o_mem_read,
    input  logic         o_mem_write,
    input  logic         o_reg_write,
    input  logic         o_branch,
    input  logic         o_jump,
    input  logic [4:0]   o_reg_dst,
    input  logic [2:0]   o_word_size,
    input  logic [31:0]  o_imm_ext
);

    logic [45:0] out_bus;

    assign out_bus = {o_alu_src, o_mem_read, o_mem_write, o_reg_write, o_branch, o_jump,
                      o_reg_dst, o_word_size, o_imm_ext};

    // The output request may only drop after the sink has acknowledged it.
    assert property (@(posedge i_clk) disable iff (i_rst)
        $fell(o_dec_req) |-> $past(i_dec_ack))
        else $error("o_dec_req fell without i_dec_ack");

    assert property (@(posedge i_clk) disable iff (i_rst)
        (o_dec_req && $past(o_dec_req)) |-> $stable(out_bus))
        else $error("decoded outputs changed while o_dec_req was high");

    // The source may drop its request as soon as it sees the ack, so look at the edge
    // on which the ack was registered.
    assert property (@(posedge i_clk) disable iff (i_rst)
        $rose(o_instr_ack) |-> $past(i_instr_req))
        else $error("o_instr_ack rose while i_instr_req was low");

    assert property (@(posedge i_clk)
        $past(i_rst) |-> (!o_dec_req && !o_instr_ack))
        else $error("handshake outputs not low after reset");

endmodule

bind decode_top decode_top_props u_props (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_instr_req (i_instr_req),
    .o_instr_ack (o_instr_ack),
    .o_dec_req   (o_dec_req),
    .i_dec_ack   (i_dec_ack),
    .o_alu_src   (o_alu_src),
    .o_mem_read  (o_mem_read),
    .o_mem_write (o_mem_write),
    .o_reg_write (o_reg_write),
    .o_branch    (o_branch),
    .o_jump      (o_jump),
    .o_reg_dst   (o_reg_dst),
    .o_word_size (o_word_size),
    .o_imm_ext   (o_imm_ext)
);

`default_nettype wire

//--- tb_decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode_top;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_WORDS    = 10 + 3 * decode_ctrl_pkg::NUM_LANES + 4;
    localparam int WATCHDOG_NS  = (NUM_WORDS * 200 + 2 * RESET_CYCLES) * CLK_PERIOD;

    logic         i_clk;
    logic         i_rst;
    logic         i_instr_req;
    logic         o_instr_ack;
    logic [31:0]  i_instr;
    logic         o_dec_req;
    logic         i_dec_ack;
    logic         o_alu_src;
    logic         o_mem_read;
    logic         o_mem_write;
    logic         o_reg_write;
    logic         o_branch;
    logic         o_jump;
    logic [4:0]   o_reg_dst;
    logic [2:0]   o_word_size;
    logic [31:0]  o_imm_ext;

    integer       seed;
    int           errors;
    int           checks;
    int           tests;
    int           err_mark;
    int           max_delay;
    logic         hold_ack;
    logic [45:0]  exp_q [$];

    decode_top i_dut (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_instr_req (i_instr_req),
        .o_instr_ack (o_instr_ack),
        .i_instr     (i_instr),
        .o_dec_req   (o_dec_req),
        .i_dec_ack   (i_dec_ack),
        .o_alu_src   (o_alu_src),
        .o_mem_read  (o_mem_read),
        .o_mem_write (o_mem_write),
        .o_reg_write (o_reg_write),
        .o_branch    (o_branch),
        .o_jump      (o_jump),
        .o_reg_dst   (o_reg_dst),
        .o_word_size (o_word_size),
        .o_imm_ext   (o_imm_ext)
    );

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    // Expected result packed as flags, destination, size and extended immediate.
    function automatic logic [45:0] model_decode(input logic [31:0] w);
        logic [5:0]  flags;
        logic [4:0]  dst;
        logic [2:0]  size;
        logic [31:0] imm;
        flags = 6'b000000;
        dst   = 5'd0;
        size  = decode_ctrl_pkg::WORD_FULL;
        imm   = {{16{w[15]}}, w[15:0]};
        // Flag order is alu_src, mem_read, mem_write, reg_write, branch, jump.
        case (w[31:26])
            mips_isa_pkg::OP_RTYPE: begin
                flags = 6'b000100;
                dst   = w[15:11];
            end
            mips_isa_pkg::OP_ADDI: begin
                flags = 6'b100100;
                dst   = w[20:16];
            end
            mips_isa_pkg::OP_ANDI: begin
                flags = 6'b100100;
                dst   = w[20:16];
                imm   = {16'h0000, w[15:0]};
            end
            mips_isa_pkg::OP_BEQ:  flags = 6'b000010;
            mips_isa_pkg::OP_JUMP: begin
                flags = 6'b000001;
                dst   = w[20:16];
                imm   = {6'b000000, w[25:0]};
            end
            mips_isa_pkg::OP_LW: begin
                flags = 6'b110100;
                dst   = w[20:16];
            end
            mips_isa_pkg::OP_LB: begin
                flags = 6'b110100;
                dst   = w[20:16];
                size  = decode_ctrl_pkg::WORD_BYTE;
            end
            mips_isa_pkg::OP_SW:   flags = 6'b101000;
            mips_isa_pkg::OP_SB: begin
                flags = 6'b101000;
                size  = decode_ctrl_pkg::WORD_BYTE;
            end
            default: ;
        endcase
        return {flags, dst, size, imm};
    endfunction

    function automatic logic [5:0] random_opcode();
        case ($unsigned($random(seed)) % 9)
            0:       return mips_isa_pkg::OP_RTYPE;
            1:       return mips_isa_pkg::OP_ADDI;
            2:       return mips_isa_pkg::OP_ANDI;
            3:       return mips_isa_pkg::OP_BEQ;
            4:       return mips_isa_pkg::OP_JUMP;
            5:       return mips_isa_pkg::OP_LW;
            6:       return mips_isa_pkg::OP_LB;
            7:       return mips_isa_pkg::OP_SW;
            default: return mips_isa_pkg::OP_SB;
        endcase
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act == exp) else begin
            $display("CHECK FAILED %s expected 0x%h got 0x%h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_result();
        logic [45:0] exp;
        if (exp_q.size() == 0) begin
            $display("A result appeared on the output link with no word outstanding");
            errors++;
        end else begin
            exp = exp_q.pop_front();
            check_field("o_alu_src", 32'(exp[45]), 32'(o_alu_src));
            check_field("o_mem_read", 32'(exp[44]), 32'(o_mem_read));
            check_field("o_mem_write", 32'(exp[43]), 32'(o_mem_write));
            check_field("o_reg_write", 32'(exp[42]), 32'(o_reg_write));
            check_field("o_branch", 32'(exp[41]), 32'(o_branch));
            check_field("o_jump", 32'(exp[40]), 32'(o_jump));
            check_field("o_reg_dst", 32'(exp[39:35]), 32'(o_reg_dst));
            check_field("o_word_size", 32'(exp[34:32]), 32'(o_word_size));
            check_field("o_imm_ext", exp[31:0], o_imm_ext);
        end
    endtask

    // Output sink. It checks each new result and acknowledges it after a delay.
    initial begin : result_sink
        int wait_cnt;
        i_dec_ack = 1'b0;
        forever begin
            @(negedge i_clk);
            if (!i_rst && o_dec_req && !i_dec_ack) begin
                check_result();
                wait_cnt = (max_delay == 0) ? 0 :
                           int'($unsigned($random(seed)) % (max_delay + 1));
                while (!i_rst && (hold_ack || wait_cnt > 0)) begin
                    @(negedge i_clk);
                    if (wait_cnt > 0) begin
                        wait_cnt--;
                    end
                end
                if (!i_rst) begin
                    i_dec_ack = 1'b1;
                    while (!i_rst && o_dec_req) @(negedge i_clk);
                end
                i_dec_ack = 1'b0;
            end
        end
    end

    task automatic apply_reset();
        @(negedge i_clk);
        i_rst       = 1'b1;
        i_instr_req = 1'b0;
        hold_ack    = 1'b0;
        exp_q.delete();
        repeat (RESET_CYCLES) @(negedge i_clk);
        i_rst = 1'b0;
    endtask

    task automatic send_word(input logic [31:0] w);
        @(negedge i_clk);
        i_instr     = w;
        i_instr_req = 1'b1;
        exp_q.push_back(model_decode(w));
        do @(negedge i_clk); while (!o_instr_ack);
        i_instr_req = 1'b0;
        do @(negedge i_clk); while (o_instr_ack);
    endtask

    task automatic finish_test(input string name);
        while (exp_q.size() != 0 || o_dec_req || i_dec_ack) @(negedge i_clk);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
        err_mark = errors;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        seed        = 32'hb9285e0e;
        i_rst       = 1'b1;
        i_instr_req = 1'b0;
        i_instr     = '0;
        hold_ack    = 1'b0;
        max_delay   = 0;
        errors      = 0;
        checks      = 0;
        tests       = 0;
        err_mark    = 0;
        apply_reset();

        send_word({mips_isa_pkg::OP_RTYPE, 5'd3, 5'd4, 5'd9, 5'd0, 6'h20});
        finish_test("r-type");

        send_word({mips_isa_pkg::OP_ADDI, 5'd1, 5'd2, 16'hfff6});
        send_word({mips_isa_pkg::OP_ANDI, 5'd1, 5'd2, 16'hfff6});
        finish_test("addi and andi");

        send_word({mips_isa_pkg::OP_LW, 5'd29, 5'd8, 16'h8004});
        send_word({mips_isa_pkg::OP_LB, 5'd29, 5'd9, 16'hfffc});
        send_word({mips_isa_pkg::OP_SW, 5'd29, 5'd10, 16'h0010});
        send_word({mips_isa_pkg::OP_SB, 5'd29, 5'd11, 16'hff01});
        finish_test("loads and stores");

        send_word({mips_isa_pkg::OP_BEQ, 5'd1, 5'd2, 16'hfffe});
        send_word({mips_isa_pkg::OP_JUMP, 26'h2abcdef});
        send_word({6'b111111, 26'h155aa55});
        finish_test("branch, jump and undefined");

        max_delay = 12;
        for (int k = 0; k < 3 * decode_ctrl_pkg::NUM_LANES; k++) begin
            send_word({random_opcode(), 26'($random(seed))});
        end
        finish_test("back-pressure");

        // Fill some lanes while the output is stalled, then reset mid-stream.
        max_delay = 0;
        hold_ack  = 1'b1;
        send_word({mips_isa_pkg::OP_ADDI, 5'd5, 5'd6, 16'h1234});
        send_word({mips_isa_pkg::OP_LW, 5'd7, 5'd8, 16'h0040});
        send_word({mips_isa_pkg::OP_BEQ, 5'd9, 5'd10, 16'h0002});
        apply_reset();
        send_word({mips_isa_pkg::OP_ANDI, 5'd12, 5'd13, 16'h8001});
        finish_test("reset mid-stream");
        repeat (20) @(negedge i_clk);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
mips_isa_pkg.sv
decode_ctrl_pkg.sv
decode_result_if.sv
control_unit.sv
decode_lane.sv
decode_dispatcher.sv
decode_collector.sv
decode_top.sv
decode_top_props.sv
tb_decode_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the decode stage testbench with Verilator, run it, and check the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f verilog.f --top-module tb_decode_top -Mdir obj_dir \
    && ./obj_dir/Vtb_decode_top > sim.log 2>&1 \
    || echo "build or simulation did not complete"
grep -q "TB PASSED" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
